// ==== design/frame_pkg.sv ====
package frame_pkg;

  localparam int TDATA_W         = 128;
  localparam int DOUT_W          = 64;
  localparam int TS_W            = 48;
  localparam int FIRST_TS_W      = 24;
  localparam int LATER_TS_W      = 24;
  localparam int ADC_W           = 12;
  localparam int THR_W           = 13;
  localparam int EXT_W           = 5;
  localparam int MAX_FRAME_BEATS = 16;
  localparam int BEAT_CNT_W      = 5;
  localparam int LEN_W           = 12;
  localparam int CH_ID_W         = 4;
  localparam int ID_W            = 8;
  // footer baseline and threshold fields are one-filled to this width
  localparam int FIELD_W         = 16;
  localparam int HDR_PAD_W       = DOUT_W - ID_W - CH_ID_W - FIRST_TS_W - LEN_W;

  localparam logic [ID_W-1:0] HEADER_ID = 8'hFF;
  localparam logic [ID_W-1:0] FOOTER_ID = 8'h0F;

  localparam int DATA_FIFO_DEPTH = 64;
  localparam int INFO_FIFO_DEPTH = 8;

  typedef logic [TDATA_W-1:0]    sample_block_t;
  typedef logic [DOUT_W-1:0]     out_word_t;
  typedef logic [TS_W-1:0]       time_stamp_t;
  typedef logic [ADC_W-1:0]      adc_t;
  typedef logic [THR_W-1:0]      threshold_t;
  typedef logic [EXT_W-1:0]      ext_len_t;
  typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;
  typedef logic [LEN_W-1:0]      frame_len_t;

  // one input beat
  typedef struct packed {
    sample_block_t samples;
    time_stamp_t   time_stamp;
    adc_t          baseline;
    threshold_t    threshold;
  } acq_sample_t;

  typedef struct packed {
    out_word_t footer;
    out_word_t header;
  } frame_info_t;

  typedef enum logic {
    W_IDLE,
    W_FRAME
  } wr_state_t;

  typedef enum logic [2:0] {
    R_IDLE,
    R_POP,
    R_HEADER,
    R_DATA_HI,
    R_DATA_LO,
    R_FOOTER
  } rd_state_t;

endpackage

// ==== design/trigger_stretcher.sv ====
`timescale 1ns/1ps

module trigger_stretcher (
  input  logic                WR_CLK,
  input  logic                WR_RESETN,
  input  frame_pkg::ext_len_t ext_len,
  input  logic                trig,
  output logic                stretched
);
  import frame_pkg::*;

  ext_len_t len_q;
  ext_len_t cnt_q;

  always_ff @(posedge WR_CLK) begin
    if (!WR_RESETN) begin
      // length is taken while in reset and held afterwards
      len_q <= ext_len;
      cnt_q <= '0;
    end else if (trig) begin
      cnt_q <= len_q;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // tail of ext_len cycles after trig falls
  assign stretched = trig || (cnt_q != '0);

endmodule

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic             WR_CLK,
  input  logic             WR_RESETN,
  input  logic             we,
  input  logic [WIDTH-1:0] wdata,
  input  logic             re,
  output logic [WIDTH-1:0] rdata,
  output logic             full,
  output logic             empty
);

  logic [WIDTH-1:0]             mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;

  always_ff @(posedge WR_CLK) begin
    if (we) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge WR_CLK) begin
    if (!WR_RESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (we) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (re) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({we, re})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // show-ahead head entry
  assign rdata = mem[rd_ptr];
  assign full  = (count == DEPTH);
  assign empty = (count == 0);

  // the controller upstream must respect the flags
  a_no_overflow: assert property (@(posedge WR_CLK) disable iff (!WR_RESETN)
    full |-> !we)
    else $error("sync_fifo write while full");

  a_no_underflow: assert property (@(posedge WR_CLK) disable iff (!WR_RESETN)
    empty |-> !re)
    else $error("sync_fifo read while empty");

endmodule

// ==== design/info_builder.sv ====
`timescale 1ns/1ps

module info_builder #(
  parameter logic [frame_pkg::CH_ID_W-1:0] CHANNEL_ID = '0
) (
  input  logic                   WR_CLK,
  input  logic                   WR_RESETN,
  input  frame_pkg::acq_sample_t smp,
  input  logic                   frame_start,
  input  frame_pkg::beat_cnt_t   beat_count,
  output frame_pkg::frame_info_t rec
);
  import frame_pkg::*;

  logic [FIRST_TS_W-1:0] ts_lo_q;
  logic [LATER_TS_W-1:0] ts_hi_q;
  adc_t                  baseline_q;
  threshold_t            threshold_q;
  logic [FIRST_TS_W-1:0] ts_lo;
  logic [LATER_TS_W-1:0] ts_hi;
  adc_t                  baseline;
  threshold_t            threshold;
  frame_len_t            len;

  // fields of the first beat of a frame
  always_ff @(posedge WR_CLK) begin
    if (!WR_RESETN) begin
      ts_lo_q     <= '0;
      ts_hi_q     <= '0;
      baseline_q  <= '0;
      threshold_q <= '0;
    end else if (frame_start) begin
      ts_lo_q     <= smp.time_stamp[FIRST_TS_W-1:0];
      ts_hi_q     <= smp.time_stamp[TS_W-1 -: LATER_TS_W];
      baseline_q  <= smp.baseline;
      threshold_q <= smp.threshold;
    end
  end

  // a one-beat frame closes in its own start cycle, so bypass the latch
  assign ts_lo     = frame_start ? smp.time_stamp[FIRST_TS_W-1:0] : ts_lo_q;
  assign ts_hi     = frame_start ? smp.time_stamp[TS_W-1 -: LATER_TS_W] : ts_hi_q;
  assign baseline  = frame_start ? smp.baseline : baseline_q;
  assign threshold = frame_start ? smp.threshold : threshold_q;

  // two output words per beat
  assign len = frame_len_t'({beat_count, 1'b0});

  assign rec.header = {HEADER_ID, CHANNEL_ID, ts_lo, {HDR_PAD_W{1'b0}}, len};
  assign rec.footer = {{(FIELD_W - ADC_W){1'b1}}, baseline,
                       {(FIELD_W - THR_W){1'b1}}, threshold,
                       ts_hi, FOOTER_ID};

endmodule

// ==== design/frame_serializer.sv ====
`timescale 1ns/1ps

module frame_serializer (
  input  logic                     WR_CLK,
  input  logic                     WR_RESETN,
  input  frame_pkg::rd_state_t     rd_state,
  input  frame_pkg::frame_info_t   info,
  input  frame_pkg::sample_block_t data,
  output frame_pkg::out_word_t     dout,
  output logic                     out_valid
);
  import frame_pkg::*;

  out_word_t word_d;
  logic      valid_d;

  always_comb begin
    case (rd_state)
      R_HEADER:  word_d = info.header;
      R_DATA_HI: word_d = data[TDATA_W-1 -: DOUT_W];
      R_DATA_LO: word_d = data[DOUT_W-1:0];
      default:   word_d = info.footer;
    endcase
  end

  assign valid_d = (rd_state inside {R_HEADER, R_DATA_HI, R_DATA_LO, R_FOOTER});

  always_ff @(posedge WR_CLK) begin
    dout <= word_d;
  end

  always_ff @(posedge WR_CLK) begin
    if (!WR_RESETN) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= valid_d;
    end
  end

  // a frame only ends after its footer word
  a_frame_contiguous: assert property (@(posedge WR_CLK) disable iff (!WR_RESETN)
    $fell(out_valid) |-> ($past(rd_state, 2) == R_FOOTER))
    else $error("out_valid dropped inside a frame");

endmodule

// ==== design/frame_ctrl.sv ====
`timescale 1ns/1ps

module frame_ctrl (
  input  logic                  WR_CLK,
  input  logic                  WR_RESETN,
  input  logic                  stretched,
  input  logic                  out_ready,
  input  logic                  data_full,
  input  logic                  info_full,
  input  logic                  data_empty,
  input  logic                  info_empty,
  input  frame_pkg::frame_len_t info_len,
  output logic                  in_ready,
  output logic                  data_we,
  output logic                  info_we,
  output logic                  data_re,
  output logic                  info_re,
  output logic                  frame_start,
  output frame_pkg::beat_cnt_t  beat_count,
  output frame_pkg::rd_state_t  rd_state
);
  import frame_pkg::*;

  wr_state_t  wr_state;
  beat_cnt_t  cnt_q;
  logic       accept;
  logic       acc_q;
  logic       last_beat;
  rd_state_t  rd_next;
  frame_len_t word_cnt;

  assign in_ready = !data_full && !info_full;
  assign accept   = stretched && in_ready;

  // sample register in the top holds the beat accepted last cycle
  assign data_we    = acc_q;
  assign beat_count = cnt_q + 1'b1;

  // frame ends when acceptance stops or the frame is full
  assign last_beat   = !accept || (beat_count == beat_cnt_t'(MAX_FRAME_BEATS));
  assign frame_start = data_we && (wr_state == W_IDLE);
  assign info_we     = data_we && last_beat;

  always_ff @(posedge WR_CLK) begin
    if (!WR_RESETN) begin
      acc_q    <= 1'b0;
      wr_state <= W_IDLE;
      cnt_q    <= '0;
    end else begin
      acc_q <= accept;
      if (info_we) begin
        wr_state <= W_IDLE;
        cnt_q    <= '0;
      end else if (data_we) begin
        wr_state <= W_FRAME;
        cnt_q    <= beat_count;
      end
    end
  end

  always_comb begin
    rd_next = rd_state;
    case (rd_state)
      R_IDLE: begin
        // downstream ready is only looked at here
        if (!info_empty && !data_empty && out_ready) begin
          rd_next = R_POP;
        end
      end
      R_POP:     rd_next = R_HEADER;
      R_HEADER:  rd_next = R_DATA_HI;
      R_DATA_HI: rd_next = R_DATA_LO;
      R_DATA_LO: begin
        if (word_cnt + 1'b1 == info_len) begin
          rd_next = R_FOOTER;
        end else begin
          rd_next = R_DATA_HI;
        end
      end
      R_FOOTER:  rd_next = R_IDLE;
      default:   rd_next = R_IDLE;
    endcase
  end

  always_ff @(posedge WR_CLK) begin
    if (!WR_RESETN) begin
      rd_state <= R_IDLE;
      word_cnt <= '0;
    end else begin
      rd_state <= rd_next;
      if (rd_state == R_POP) begin
        word_cnt <= '0;
      end else if (rd_state == R_DATA_HI || rd_state == R_DATA_LO) begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // data beat leaves after its low half, info record after the footer
  assign data_re = (rd_state == R_DATA_LO);
  assign info_re = (rd_state == R_FOOTER);

  a_beat_limit: assert property (@(posedge WR_CLK) disable iff (!WR_RESETN)
    data_we |-> (beat_count <= beat_cnt_t'(MAX_FRAME_BEATS)))
    else $error("frame beat count above limit");

endmodule

// ==== design/frame_gen_top.sv ====
`timescale 1ns/1ps

module frame_gen_top #(
  parameter logic [frame_pkg::CH_ID_W-1:0] CHANNEL_ID = '0
) (
  input  logic                   WR_CLK,
  input  logic                   WR_RESETN,
  input  frame_pkg::ext_len_t    ext_len,
  input  logic                   trig,
  input  frame_pkg::acq_sample_t sample,
  output logic                   in_ready,
  input  logic                   out_ready,
  output logic                   out_valid,
  output frame_pkg::out_word_t   dout
);
  import frame_pkg::*;

  logic          stretched;
  acq_sample_t   smp_q;
  logic          data_we;
  logic          data_re;
  logic          data_full;
  logic          data_empty;
  sample_block_t data_head;
  logic          info_we;
  logic          info_re;
  logic          info_full;
  logic          info_empty;
  frame_info_t   info_head;
  frame_info_t   rec;
  logic          frame_start;
  beat_cnt_t     beat_count;
  rd_state_t     rd_state;

  // one-cycle input register, written to the FIFO when accepted
  always_ff @(posedge WR_CLK) begin
    smp_q <= sample;
  end

  trigger_stretcher trigger_stretcher_i (
    .WR_CLK    (WR_CLK),
    .WR_RESETN (WR_RESETN),
    .ext_len   (ext_len),
    .trig      (trig),
    .stretched (stretched)
  );

  frame_ctrl frame_ctrl_i (
    .WR_CLK      (WR_CLK),
    .WR_RESETN   (WR_RESETN),
    .stretched   (stretched),
    .out_ready   (out_ready),
    .data_full   (data_full),
    .info_full   (info_full),
    .data_empty  (data_empty),
    .info_empty  (info_empty),
    .info_len    (info_head.header[LEN_W-1:0]),
    .in_ready    (in_ready),
    .data_we     (data_we),
    .info_we     (info_we),
    .data_re     (data_re),
    .info_re     (info_re),
    .frame_start (frame_start),
    .beat_count  (beat_count),
    .rd_state    (rd_state)
  );

  info_builder #(
    .CHANNEL_ID (CHANNEL_ID)
  ) info_builder_i (
    .WR_CLK      (WR_CLK),
    .WR_RESETN   (WR_RESETN),
    .smp         (smp_q),
    .frame_start (frame_start),
    .beat_count  (beat_count),
    .rec         (rec)
  );

  sync_fifo #(
    .WIDTH (TDATA_W),
    .DEPTH (DATA_FIFO_DEPTH)
  ) data_fifo_i (
    .WR_CLK    (WR_CLK),
    .WR_RESETN (WR_RESETN),
    .we        (data_we),
    .wdata     (smp_q.samples),
    .re        (data_re),
    .rdata     (data_head),
    .full      (data_full),
    .empty     (data_empty)
  );

  sync_fifo #(
    .WIDTH ($bits(frame_info_t)),
    .DEPTH (INFO_FIFO_DEPTH)
  ) info_fifo_i (
    .WR_CLK    (WR_CLK),
    .WR_RESETN (WR_RESETN),
    .we        (info_we),
    .wdata     (rec),
    .re        (info_re),
    .rdata     (info_head),
    .full      (info_full),
    .empty     (info_empty)
  );

  frame_serializer frame_serializer_i (
    .WR_CLK    (WR_CLK),
    .WR_RESETN (WR_RESETN),
    .rd_state  (rd_state),
    .info      (info_head),
    .data      (data_head),
    .dout      (dout),
    .out_valid (out_valid)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic resetn
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // low for the first two rising edges
  initial begin
    resetn = 1'b0;
    repeat (2) @(posedge clk);
    #1 resetn = 1'b1;
  end

endmodule

// ==== testbench/tb_frame_gen.sv ====
`timescale 1ns/1ps

module tb_frame_gen;
  import frame_pkg::*;

  localparam logic [3:0] CH_ID     = 4'h5;
  localparam int         EXT_LEN   = 3;
  localparam int         MAX_LINES = 16;

  logic          wr_clk;
  logic          wr_resetn;
  ext_len_t      ext_len;
  logic          trig;
  acq_sample_t   sample;
  logic          in_ready;
  logic          out_ready;
  logic          out_valid;
  out_word_t     dout;

  logic [15:0]   burst_mem [MAX_LINES*4];
  logic [31:0]   lfsr = 32'h586b;
  logic [47:0]   cycle = '0;
  int            cycle_limit = 0;
  int            since_trig = EXT_LEN + 1;
  sample_block_t beats_q [$];
  time_stamp_t   f_ts;
  adc_t          f_bl;
  threshold_t    f_thr;
  out_word_t     exp_q [$];
  bit            last_q [$];
  out_word_t     exp_word;
  int            total_frames = 0;
  int            model_frames = 0;
  int            frames_seen = 0;
  int            value_errs = 0;
  int            proto_errs = 0;
  logic          prev_valid = 1'b0;
  logic          prev_last = 1'b0;
  logic [2:0]    rdy_hist = '1;

  tb_clock_gen clock_gen_i (
    .clk    (wr_clk),
    .resetn (wr_resetn)
  );

  frame_gen_top #(
    .CHANNEL_ID (CH_ID)
  ) frame_gen_top_i (
    .WR_CLK    (wr_clk),
    .WR_RESETN (wr_resetn),
    .ext_len   (ext_len),
    .trig      (trig),
    .sample    (sample),
    .in_ready  (in_ready),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .dout      (dout)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output sample_block_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = next_lfsr(lfsr);
      v = {v[TDATA_W-2:0], lfsr[0]};
    end
  endtask

  // header, high then low half of each beat, footer
  task automatic close_frame();
    int n;
    n = beats_q.size();
    exp_q.push_back({8'hFF, CH_ID, f_ts[23:0], 16'h0000, 12'(2 * n)});
    last_q.push_back(1'b0);
    foreach (beats_q[i]) begin
      exp_q.push_back(beats_q[i][127:64]);
      exp_q.push_back(beats_q[i][63:0]);
      last_q.push_back(1'b0);
      last_q.push_back(1'b0);
    end
    exp_q.push_back({4'hF, f_bl, 3'b111, f_thr, f_ts[47:24], 8'h0F});
    last_q.push_back(1'b1);
    beats_q.delete();
    model_frames++;
  endtask

  task automatic drive_cycle(input logic trig_v, input logic ready_v);
    sample_block_t bits;
    logic          keep;
    take_bits(TDATA_W, bits);
    sample.samples = bits;
    take_bits(ADC_W, bits);
    sample.baseline = bits[ADC_W-1:0];
    take_bits(THR_W, bits);
    sample.threshold = bits[THR_W-1:0];
    sample.time_stamp = cycle;
    trig = trig_v;
    out_ready = ready_v;
    // kept while trig is high and for EXT_LEN cycles after it falls
    if (trig_v) begin
      since_trig = 0;
    end else if (since_trig <= EXT_LEN) begin
      since_trig++;
    end
    keep = trig_v || (since_trig <= EXT_LEN);
    if (keep) begin
      if (beats_q.size() == 0) begin
        f_ts  = cycle;
        f_bl  = sample.baseline;
        f_thr = sample.threshold;
      end
      beats_q.push_back(sample.samples);
      if (beats_q.size() == 16) begin
        close_frame();
      end
    end else if (beats_q.size() != 0) begin
      close_frame();
    end
  endtask

  task automatic print_counts();
    $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
  endtask

  always @(posedge wr_clk) begin
    cycle <= cycle + 1'b1;
    if (cycle_limit != 0 && cycle >= cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycle_limit);
      print_counts();
      $display("Some tests failed");
      $finish;
    end
  end

  // output monitor
  always @(negedge wr_clk) begin
    if (wr_resetn) begin
      assert (in_ready) else begin
        proto_errs++;
        $display("CHECK FAILED at %0t: in_ready low", $time);
      end
      // a frame starts three cycles after out_ready is seen in idle
      assert (!(out_valid && !prev_valid) || rdy_hist[2]) else begin
        proto_errs++;
        $display("CHECK FAILED at %0t: frame started without out_ready", $time);
      end
      assert (!prev_valid || prev_last || out_valid) else begin
        proto_errs++;
        $display("CHECK FAILED at %0t: out_valid dropped inside a frame", $time);
      end
      assert (!(prev_valid && prev_last) || !out_valid) else begin
        proto_errs++;
        $display("CHECK FAILED at %0t: no idle cycle after footer", $time);
      end
      prev_last = 1'b0;
      if (out_valid) begin
        assert (exp_q.size() != 0) else begin
          value_errs++;
          $display("CHECK FAILED at %0t: word %h with none expected", $time, dout);
        end
        if (exp_q.size() != 0) begin
          exp_word = exp_q.pop_front();
          prev_last = last_q.pop_front();
          frames_seen += prev_last;
          assert (dout === exp_word) else begin
            value_errs++;
            $display("CHECK FAILED at %0t: dout %h, expected %h", $time, dout, exp_word);
          end
        end
      end
      prev_valid = out_valid;
    end
    rdy_hist = {rdy_hist[1:0], out_ready};
  end

  initial begin
    int n_lines;
    int sum_len;
    int trig_len;
    int hold_len;
    int dur;
    ext_len   = ext_len_t'(EXT_LEN);
    trig      = 1'b0;
    sample    = '0;
    out_ready = 1'b1;
    n_lines   = 0;
    sum_len   = 0;
    $readmemh("testbench/frame_input.txt", burst_mem);
    while (n_lines < MAX_LINES && !$isunknown(burst_mem[4*n_lines])) begin
      sum_len += burst_mem[4*n_lines] + burst_mem[4*n_lines+1] + burst_mem[4*n_lines+2];
      total_frames += burst_mem[4*n_lines+3];
      n_lines++;
    end
    if (n_lines == 0) begin
      $display("no bursts could be read from testbench/frame_input.txt");
      proto_errs++;
    end
    cycle_limit = 2 * sum_len + 200;
    @(posedge wr_resetn);
    @(negedge wr_clk);
    assert (!out_valid && in_ready) else begin
      proto_errs++;
      $display("CHECK FAILED at %0t: after reset out_valid %b in_ready %b",
               $time, out_valid, in_ready);
    end
    for (int l = 0; l < n_lines; l++) begin
      trig_len = burst_mem[4*l];
      hold_len = burst_mem[4*l+2];
      dur = trig_len + burst_mem[4*l+1];
      dur = (hold_len > dur) ? hold_len : dur;
      for (int i = 0; i < dur; i++) begin
        @(posedge wr_clk);
        #1;
        drive_cycle(i < trig_len, i >= hold_len);
      end
    end
    while (exp_q.size() != 0 || out_valid) begin
      @(negedge wr_clk);
    end
    repeat (10) @(negedge wr_clk);
    assert (frames_seen == total_frames && model_frames == total_frames) else begin
      value_errs++;
      $display("CHECK FAILED at %0t: frames seen %0d, model %0d, file %0d",
               $time, frames_seen, model_frames, total_frames);
    end
    print_counts();
    if (value_errs + proto_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
design/frame_pkg.sv
design/trigger_stretcher.sv
design/sync_fifo.sv
design/info_builder.sv
design/frame_serializer.sv
design/frame_ctrl.sv
design/frame_gen_top.sv
testbench/tb_clock_gen.sv
testbench/tb_frame_gen.sv

// ==== testbench/frame_input.txt ====
// columns: trigger cycles, gap cycles, out_ready hold-off cycles,
// frames closed during the line; all values hex, ext_len is 3
5  8  0  1
// next two lines merge into one frame of 12 beats
3  2  0  0
4  A  0  1
// 23 beats split into 16 and 7
14 30 0  2
// exactly 16 beats
D  30 0  1
// frames held back while out_ready is low
6  6  40 1
22 8  50 3
2  10 0  1
